// File: run.sh
#!/bin/sh
# Build the core slice testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module core_tb -f tb.f -o core_tb_sim

out=$(./obj_dir/core_tb_sim)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// File: source/core_exec.sv
/*
 * Decode, execute and writeback of the RV32I subset, one per cycle.
 * Never stalls. Unknown encodings retire without a register write.
 * Trace and writeback outputs appear one cycle after the pop.
 */
`timescale 1ns/1ps
`default_nettype none

module core_exec import core_pkg::*; (
    input  wire        g_clk,          // Core clock
    input  wire        rst_n,          // Async active low reset
    input  wire        head_valid,     // Queue head present
    input  wire word_t head_instr,     // Instruction to execute
    input  wire word_t head_pc,        // Its PC
    output logic       pop,            // Consume queue head
    output logic       credit_return,  // Slot freed on sequential pop
    output logic       cf_valid,       // Taken jump or branch
    output word_t      cf_target,      // Its destination
    output logic       trs_valid,      // Retired instruction trace
    output word_t      trs_instr,
    output word_t      trs_pc,
    output logic       rd_wen,         // Register write of that instruction
    output reg_addr_t  rd_addr,
    output word_t      rd_wdata
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_b;
    word_t      result;                // Value for rd
    logic       writes_rd;             // Supported op with a destination
    logic       taken;                 // Jump or branch redirects
    logic       wen;                   // GPR write this cycle

    // ------------------------------------------------------------
    // Field and immediate decode
    // ------------------------------------------------------------

    assign opcode = head_instr[6:0];
    assign rd     = head_instr[11:7];
    assign funct3 = head_instr[14:12];
    assign rs1    = head_instr[19:15];
    assign rs2    = head_instr[24:20];
    assign funct7 = head_instr[31:25];

    assign imm_i = {{20{head_instr[31]}}, head_instr[31:20]};
    assign imm_u = {head_instr[31:12], 12'b0};
    assign imm_j = {{12{head_instr[31]}}, head_instr[19:12], head_instr[20],
                    head_instr[30:21], 1'b0};
    assign imm_b = {{20{head_instr[31]}}, head_instr[7], head_instr[30:25],
                    head_instr[11:8], 1'b0};

    // ------------------------------------------------------------
    // ALU and branch unit
    // ------------------------------------------------------------

    always_comb begin
        result    = '0;
        writes_rd = 1'b0;
        taken     = 1'b0;
        cf_target = head_pc + imm_b;   // Branch target unless JAL
        case (opcode)
            OPC_OP: begin
                // Only funct7 zero, or SUB with bit 30 set
                writes_rd = (funct7 == 7'b0) ||
                            (funct7 == 7'b0100000 && funct3 == F3_ADD_SUB);
                case (funct3)
                    F3_ADD_SUB: result = funct7[5] ? rs1_data - rs2_data
                                                   : rs1_data + rs2_data;
                    F3_XOR:     result = rs1_data ^ rs2_data;
                    F3_OR:      result = rs1_data | rs2_data;
                    F3_AND:     result = rs1_data & rs2_data;
                    default:    writes_rd = 1'b0;  // Shifts, compares
                endcase
            end
            OPC_OP_IMM: begin
                writes_rd = 1'b1;
                case (funct3)
                    F3_ADD_SUB: result = rs1_data + imm_i;
                    F3_XOR:     result = rs1_data ^ imm_i;
                    F3_OR:      result = rs1_data | imm_i;
                    F3_AND:     result = rs1_data & imm_i;
                    default:    writes_rd = 1'b0;
                endcase
            end
            OPC_LUI: begin
                writes_rd = 1'b1;
                result    = imm_u;
            end
            OPC_JAL: begin
                writes_rd = 1'b1;
                result    = head_pc + 32'd4;   // Link address
                taken     = 1'b1;
                cf_target = head_pc + imm_j;
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  taken = (rs1_data == rs2_data);
                    F3_BNE:  taken = (rs1_data != rs2_data);
                    default: taken = 1'b0;     // Other compares not handled
                endcase
            end
            default: writes_rd = 1'b0;         // Retires as a no-op
        endcase
    end

    assign pop           = head_valid;         // Never stalls
    assign cf_valid      = pop && taken;
    assign credit_return = pop && !taken;      // Redirect refills fetch credits
    assign wen           = pop && writes_rd && (rd != '0);

    core_regfile i_core_regfile (
        .g_clk    (g_clk   ),
        .rst_n    (rst_n   ),
        .rs1_addr (rs1     ),
        .rs2_addr (rs2     ),
        .wen      (wen     ),
        .waddr    (rd      ),
        .wdata    (result  ),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // ------------------------------------------------------------
    // Trace and writeback registers
    // ------------------------------------------------------------

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            trs_valid <= 1'b0;
            rd_wen    <= 1'b0;
        end else begin
            trs_valid <= pop;
            rd_wen    <= wen;                  // Low for x0 targets
        end
    end

    always_ff @(posedge g_clk) begin
        if (pop) begin
            trs_instr <= head_instr;
            trs_pc    <= head_pc;
            rd_addr   <= rd;
            rd_wdata  <= result;
        end
    end

endmodule

`default_nettype wire

// File: source/core_fetch.sv
/*
 * Instruction fetch with credit based flow control into the queue.
 * A request keeps its address until granted unless execute redirects.
 * Bus errors are not observed, so an erroring fetch pushes its rdata.
 */
`timescale 1ns/1ps
`default_nettype none

module core_fetch import core_pkg::*; (
    input  wire        g_clk,          // Core clock
    input  wire        rst_n,          // Async active low reset
    input  wire        imem_gnt,       // Word delivered this cycle
    input  wire word_t imem_rdata,     // Fetched word
    input  wire        cf_valid,       // Redirect from execute
    input  wire word_t cf_target,      // Redirect address
    input  wire        credit_return,  // One queue slot freed
    output logic       imem_req,       // Fetch request
    output word_t      imem_addr,      // Word aligned fetch address
    output logic       push,           // Write word into queue
    output word_t      push_instr,     // Word being pushed
    output word_t      push_pc         // PC of that word
);

    credit_t credits;                  // Free queue slots
    credit_t credits_nxt;
    word_t   pc;                       // Address of the word being fetched

    assign imem_addr  = pc;
    assign push_instr = imem_rdata;    // Queue captures the word at the grant edge
    assign push_pc    = pc;

    // Grant in a redirect cycle belongs to the old path and is dropped
    assign push = imem_req && imem_gnt && !cf_valid && (credits != '0);

    // ------------------------------------------------------------
    // Credit counter
    // ------------------------------------------------------------

    always_comb begin
        credits_nxt = credits;
        if (cf_valid) begin
            credits_nxt = credit_t'(QUEUE_DEPTH);  // Queue empties on the same edge
        end else begin
            case ({push, credit_return})
                2'b10:   credits_nxt = credits - 1'b1;  // Slot taken
                2'b01:   credits_nxt = credits + 1'b1;  // Slot given back
                default: credits_nxt = credits;         // Idle, or both cancel
            endcase
        end
    end

    // ------------------------------------------------------------
    // PC and request
    // ------------------------------------------------------------

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            credits  <= credit_t'(QUEUE_DEPTH);
            imem_req <= 1'b0;                       // First request one cycle after reset
            pc       <= PC_RESET_ADDRESS;
        end else begin
            credits  <= credits_nxt;
            imem_req <= (credits_nxt != '0);        // Ask whenever a slot is free
            if (cf_valid) begin
                pc <= cf_target;
            end else if (push) begin
                pc <= pc + 32'd4;                   // Next sequential word
            end
        end
    end

endmodule

`default_nettype wire

// File: source/core_instr_queue.sv
/*
 * Circular FIFO of instruction and PC pairs between fetch and execute.
 * No full flag. Fetch credits keep pushes within QUEUE_DEPTH.
 * Pop must only be raised while head_valid is high.
 */
`timescale 1ns/1ps
`default_nettype none

module core_instr_queue import core_pkg::*; (
    input  wire        g_clk,          // Core clock
    input  wire        rst_n,          // Async active low reset
    input  wire        push,           // Enqueue from fetch
    input  wire word_t push_instr,     // Word to store
    input  wire word_t push_pc,        // Its PC
    input  wire        pop,            // Dequeue by execute
    input  wire        flush,          // Control flow change, drop all
    output logic       head_valid,     // Head entry present
    output word_t      head_instr,     // Oldest word
    output word_t      head_pc         // Oldest PC
);

    word_t   instr_mem [QUEUE_DEPTH];  // Instruction words
    word_t   pc_mem    [QUEUE_DEPTH];  // Matching PCs
    qptr_t   wr_ptr;                   // Next slot to fill
    qptr_t   rd_ptr;                   // Current head slot
    credit_t count;                    // Occupancy

    assign head_valid = (count != '0);
    assign head_instr = instr_mem[rd_ptr];
    assign head_pc    = pc_mem[rd_ptr];

    // Storage
    always_ff @(posedge g_clk) begin
        if (push) begin
            instr_mem[wr_ptr] <= push_instr;
            pc_mem[wr_ptr]    <= push_pc;
        end
    end

    // ------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;                      // Everything queued is wrong path
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;       // Wraps at QUEUE_DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Push and pop together hold
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/core_pkg.sv
/*
 * Widths, vector types and encodings shared by the core slice.
 * Only the RV32I subset executed by core_exec has opcode constants.
 * QUEUE_DEPTH must stay a power of two so queue pointers wrap freely.
 */
`default_nettype none

package core_pkg;

    // ------------------------------------------------------------
    // Widths and vector types
    // ------------------------------------------------------------

    localparam int XLEN = 32;                         // Data and address width

    typedef logic [XLEN-1:0] word_t;                  // PC, GPR value, instruction
    typedef logic [4:0]      reg_addr_t;              // GPR index

    localparam int QUEUE_DEPTH = 4;                   // Entries, also initial credits

    typedef logic [$clog2(QUEUE_DEPTH)-1:0]   qptr_t;   // Queue slot index
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] credit_t; // Counts 0 to QUEUE_DEPTH

    localparam word_t PC_RESET_ADDRESS = 32'h1000_0000; // First fetch after reset

    // ------------------------------------------------------------
    // Major opcodes
    // ------------------------------------------------------------

    localparam logic [6:0] OPC_OP     = 7'b0110011;   // Reg-reg ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;   // Reg-imm ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111;   // Load upper immediate
    localparam logic [6:0] OPC_JAL    = 7'b1101111;   // Jump and link
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;   // Conditional branches

    // ------------------------------------------------------------
    // funct3 codes
    // ------------------------------------------------------------

    localparam logic [2:0] F3_ADD_SUB = 3'b000;       // ADD, SUB, ADDI
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

endpackage

`default_nettype wire

// File: source/core_regfile.sv
/*
 * 32 x XLEN register file, two combinational reads, one write port.
 * x0 ignores writes and always reads zero.
 */
`timescale 1ns/1ps
`default_nettype none

module core_regfile import core_pkg::*; (
    input  wire            g_clk,      // Core clock
    input  wire            rst_n,      // Async active low reset
    input  wire reg_addr_t rs1_addr,   // Read port 1 index
    input  wire reg_addr_t rs2_addr,   // Read port 2 index
    input  wire            wen,        // Write enable
    input  wire reg_addr_t waddr,      // Write index
    input  wire word_t     wdata,      // Write value
    output word_t          rs1_data,   // Read port 1 value
    output word_t          rs2_data    // Read port 2 value
);

    word_t regs [32];                  // Architectural GPRs

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;      // Visible to the next pop
        end
    end

endmodule

`default_nettype wire

// File: source/core_top.sv
/*
 * Core slice top level. Fetch, instruction queue and execute.
 * imem_err is accepted but ignored since traps are not supported.
 */
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
    input  wire            g_clk,       // Core clock
    input  wire            rst_n,       // Async active low reset
    output wire            imem_req,    // Instruction fetch request
    output wire word_t     imem_addr,   // Fetch address
    input  wire            imem_gnt,    // Fetch completes
    input  wire            imem_err,    // Fetch error, unused
    input  wire word_t     imem_rdata,  // Fetched word
    output wire            trs_valid,   // Instruction retired
    output wire word_t     trs_instr,   // Retired word
    output wire word_t     trs_pc,      // Retired PC
    output wire            rd_wen,      // GPR write of retired instruction
    output wire reg_addr_t rd_addr,
    output wire word_t     rd_wdata
);

    // ------------------------------------------------------------
    // Inter-block wiring
    // ------------------------------------------------------------

    logic  push;                        // Fetch to queue
    word_t push_instr;
    word_t push_pc;
    logic  head_valid;                  // Queue to execute
    word_t head_instr;
    word_t head_pc;
    logic  pop;                         // Execute back to queue
    logic  credit_return;               // Execute back to fetch
    logic  cf_valid;                    // Redirect and flush
    word_t cf_target;

    core_fetch i_core_fetch (
        .g_clk         (g_clk        ),
        .rst_n         (rst_n        ),
        .imem_gnt      (imem_gnt     ),
        .imem_rdata    (imem_rdata   ),
        .cf_valid      (cf_valid     ),
        .cf_target     (cf_target    ),
        .credit_return (credit_return),
        .imem_req      (imem_req     ),
        .imem_addr     (imem_addr    ),
        .push          (push         ),
        .push_instr    (push_instr   ),
        .push_pc       (push_pc      )
    );

    core_instr_queue i_core_instr_queue (
        .g_clk      (g_clk     ),
        .rst_n      (rst_n     ),
        .push       (push      ),
        .push_instr (push_instr),
        .push_pc    (push_pc   ),
        .pop        (pop       ),
        .flush      (cf_valid  ),       // Taken control flow drops the queue
        .head_valid (head_valid),
        .head_instr (head_instr),
        .head_pc    (head_pc   )
    );

    core_exec i_core_exec (
        .g_clk         (g_clk        ),
        .rst_n         (rst_n        ),
        .head_valid    (head_valid   ),
        .head_instr    (head_instr   ),
        .head_pc       (head_pc      ),
        .pop           (pop          ),
        .credit_return (credit_return),
        .cf_valid      (cf_valid     ),
        .cf_target     (cf_target    ),
        .trs_valid     (trs_valid    ),
        .trs_instr     (trs_instr    ),
        .trs_pc        (trs_pc       ),
        .rd_wen        (rd_wen       ),
        .rd_addr       (rd_addr      ),
        .rd_wdata      (rd_wdata     )
    );

endmodule

`default_nettype wire

// File: tb.f
source/core_pkg.sv
source/core_regfile.sv
source/core_fetch.sv
source/core_instr_queue.sv
source/core_exec.sv
source/core_top.sv
verif/core_tb_assert.sv
verif/core_tb.sv

// File: verif/core_tb.sv
/*
 * Testbench for core_top with a 64 word random program at PC_RESET_ADDRESS.
 * Fixed slots hold forward JAL and BEQ/BNE pairs. Other addresses read as
 * ADDI x0 no-ops whose immediate folds in the address.
 */
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int PROG_WORDS     = 64;
    localparam int NUM_RETIRE     = 200;      // Retirements to check
    localparam int RETIRE_TIMEOUT = 200;      // Cycles allowed between retirements
    localparam int REQ_TIMEOUT    = 10;

    logic      g_clk;
    logic      rst_n;
    logic      imem_req;
    word_t     imem_addr;
    logic      imem_gnt;
    logic      imem_err;
    word_t     imem_rdata;
    logic      trs_valid;
    word_t     trs_instr;
    word_t     trs_pc;
    logic      rd_wen;
    reg_addr_t rd_addr;
    word_t     rd_wdata;

    word_t       prog [PROG_WORDS];           // Instruction memory image
    logic [31:0] lfsr;
    word_t       model_regs [32];             // Architectural model
    word_t       model_pc;
    word_t       exp_pc;
    word_t       exp_instr;
    logic        exp_wen;
    reg_addr_t   exp_rd;
    word_t       exp_wdata;
    int          errors;
    int          retired;
    int          stall;                       // Cycles left in a long stall

    core_top dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    // ------------------------------------------------------------
    // Random source and instruction encoders
    // ------------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input reg_addr_t rd, input reg_addr_t rs1,
                                         input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t itype_word(input logic [2:0] f3, input reg_addr_t rd,
                                         input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t jal_word(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t branch_word(input logic [2:0] f3, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    task automatic gen_program();
        logic [2:0] f3_list [4];
        int         kind;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [11:0] imm;
        logic [19:0] upper;
        f3_list = '{F3_ADD_SUB, F3_XOR, F3_OR, F3_AND};
        for (int i = 0; i < PROG_WORDS; i++) begin
            kind  = int'(rand_bits(4) % 10);
            rd    = reg_addr_t'(rand_bits(3));             // x0 to x7, x0 now and then
            rs1   = reg_addr_t'(rand_bits(3));
            rs2   = reg_addr_t'(rand_bits(3));
            imm   = 12'(rand_bits(12));
            upper = 20'(rand_bits(20));
            if (kind == 0) begin
                prog[i] = rtype_word(7'b0100000, F3_ADD_SUB, rd, rs1, rs2);  // SUB
            end else if (kind < 5) begin
                prog[i] = rtype_word(7'b0, f3_list[kind-1], rd, rs1, rs2);
            end else if (kind < 9) begin
                prog[i] = itype_word(f3_list[kind-5], rd, rs1, imm);
            end else begin
                prog[i] = {upper, rd, OPC_LUI};
            end
        end
        prog[10] = jal_word(5'd1, 21'd12);                   // Skips 11 and 12
        prog[20] = branch_word(F3_BEQ, 5'd2, 5'd3, 13'd12);  // One of the pair lands on 23
        prog[21] = branch_word(F3_BNE, 5'd2, 5'd3, 13'd8);
        prog[30] = branch_word(F3_BEQ, 5'd0, 5'd0, 13'd16);  // Always taken
        prog[40] = branch_word(F3_BNE, 5'd4, 5'd4, 13'd16);  // Never taken
        prog[41] = branch_word(F3_BEQ, 5'd4, 5'd4, 13'd8);   // Always taken
        prog[50] = jal_word(5'd0, 21'd8);                    // Link to x0, no write
        prog[60] = jal_word(5'd7, 21'd16);                   // Leaves the program
    endtask

    function automatic word_t mem_read(input word_t addr);
        word_t offset;
        offset = addr - PC_RESET_ADDRESS;
        if (offset < word_t'(PROG_WORDS * 4)) begin
            return prog[offset[7:2]];
        end
        return itype_word(F3_ADD_SUB, 5'd0, 5'd0, 12'(addr ^ (addr >> 12) ^ (addr >> 24)));
    endfunction

    // ------------------------------------------------------------
    // Reference model, one architectural step per retirement
    // ------------------------------------------------------------

    function automatic void model_step();
        logic [6:0]  opc;
        logic [2:0]  f3;
        reg_addr_t   rd;
        word_t       a;
        word_t       b;
        logic [20:0] joff;
        logic [12:0] boff;
        logic        wr;
        word_t       next_pc;
        exp_pc    = model_pc;
        exp_instr = mem_read(model_pc);
        opc       = exp_instr[6:0];
        rd        = exp_instr[11:7];
        f3        = exp_instr[14:12];
        a         = model_regs[exp_instr[19:15]];
        b         = model_regs[exp_instr[24:20]];
        joff      = {exp_instr[31], exp_instr[19:12], exp_instr[20], exp_instr[30:21], 1'b0};
        boff      = {exp_instr[31], exp_instr[7], exp_instr[30:25], exp_instr[11:8], 1'b0};
        next_pc   = model_pc + 32'd4;
        wr        = 1'b0;
        exp_wdata = '0;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            if (opc == OPC_OP_IMM) begin
                b = {{20{exp_instr[31]}}, exp_instr[31:20]};  // Sign extended I immediate
            end
            wr = 1'b1;
            case (f3)
                F3_ADD_SUB: exp_wdata = (opc == OPC_OP && exp_instr[30]) ? a - b : a + b;
                F3_XOR:     exp_wdata = a ^ b;
                F3_OR:      exp_wdata = a | b;
                F3_AND:     exp_wdata = a & b;
                default:    wr = 1'b0;
            endcase
        end else if (opc == OPC_LUI) begin
            wr        = 1'b1;
            exp_wdata = {exp_instr[31:12], 12'h000};
        end else if (opc == OPC_JAL) begin
            wr        = 1'b1;
            exp_wdata = model_pc + 32'd4;                     // Link address
            next_pc   = model_pc + {{11{joff[20]}}, joff};
        end else if (opc == OPC_BRANCH) begin
            if ((f3 == F3_BEQ && a == b) || (f3 == F3_BNE && a != b)) begin
                next_pc = model_pc + {{19{boff[12]}}, boff};
            end
        end
        exp_wen = wr && (rd != 5'd0);                         // x0 is never written
        exp_rd  = rd;
        if (exp_wen) begin
            model_regs[rd] = exp_wdata;
        end
        model_pc = next_pc;
    endfunction

    task automatic check_retire();
        model_step();
        if (trs_pc !== exp_pc) begin
            $display("Fail retire %0d trs_pc: expected %h, actual %h", retired, exp_pc, trs_pc);
            errors++;
        end
        if (trs_instr !== exp_instr) begin
            $display("Fail retire %0d trs_instr: expected %h, actual %h",
                     retired, exp_instr, trs_instr);
            errors++;
        end
        if (rd_wen !== exp_wen) begin
            $display("Fail retire %0d rd_wen: expected %b, actual %b", retired, exp_wen, rd_wen);
            errors++;
        end
        if (exp_wen && rd_addr !== exp_rd) begin
            $display("Fail retire %0d rd_addr: expected %0d, actual %0d",
                     retired, exp_rd, rd_addr);
            errors++;
        end
        if (exp_wen && rd_wdata !== exp_wdata) begin
            $display("Fail retire %0d rd_wdata: expected %h, actual %h",
                     retired, exp_wdata, rd_wdata);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // Memory model, random grants and long stalls
    // ------------------------------------------------------------

    initial begin : memory_model
        imem_gnt   = 1'b0;
        imem_err   = 1'b0;
        imem_rdata = '0;
        lfsr       = 32'h5dcd;
        stall      = 0;
        gen_program();
        forever begin
            @(negedge g_clk);
            if (stall > 0) begin
                stall--;
                imem_gnt = 1'b0;
            end else if (rand_bits(5) == 0) begin
                stall    = 8 + int'(rand_bits(4));          // 8 to 23 cycles
                imem_gnt = 1'b0;
            end else begin
                imem_gnt = imem_req && (rand_bits(1) != 0);
            end
            imem_rdata = mem_read(imem_addr);
        end
    end

    initial begin : main
        int wait_cycles;
        errors   = 0;
        retired  = 0;
        rst_n    = 1'b0;
        model_pc = PC_RESET_ADDRESS;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (16) @(negedge g_clk);
        rst_n       = 1'b1;
        wait_cycles = 0;
        while (!imem_req && wait_cycles < REQ_TIMEOUT) begin
            @(negedge g_clk);
            wait_cycles++;
        end
        if (!imem_req) begin
            $display("Timeout: no fetch request after reset release");
            errors++;
        end
        wait_cycles = 0;
        while (retired < NUM_RETIRE && wait_cycles < RETIRE_TIMEOUT) begin
            @(negedge g_clk);
            wait_cycles++;
            if (trs_valid) begin
                check_retire();
                retired++;
                wait_cycles = 0;
            end
        end
        if (retired < NUM_RETIRE) begin
            $display("Timeout: only %0d of %0d instructions retired", retired, NUM_RETIRE);
            errors++;
        end
        $display("Retired %0d instructions, %0d errors", retired, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/core_tb_assert.sv
/*
 * Concurrent checks on fetch credits, queue occupancy and the fetch port.
 * Bound into core_top so both fetch and queue internals are visible.
 */
`timescale 1ns/1ps
`default_nettype none

module core_tb_assert import core_pkg::*; (
    input wire          g_clk,
    input wire          rst_n,
    input wire          imem_req,
    input wire          imem_gnt,
    input wire word_t   imem_addr,
    input wire          cf_valid,      // Redirect may move a pending request
    input wire credit_t credits,       // Free slots held by fetch
    input wire credit_t occupancy      // Entries in the queue
);

    // ------------------------------------------------------------
    // Queue and credit accounting
    // ------------------------------------------------------------

    occupancy_bound: assert property (@(posedge g_clk) disable iff (!rst_n)
        occupancy <= credit_t'(QUEUE_DEPTH))
        else $error("Queue occupancy %0d above depth", occupancy);

    credit_bound: assert property (@(posedge g_clk) disable iff (!rst_n)
        ({1'b0, credits} + {1'b0, occupancy}) <= 4'(QUEUE_DEPTH))
        else $error("Credits %0d plus occupancy %0d above depth", credits, occupancy);

    // Pending request holds its address
    addr_stable: assert property (@(posedge g_clk) disable iff (!rst_n)
        imem_req && !imem_gnt && !cf_valid |=> $stable(imem_addr))
        else $error("imem_addr changed while waiting for a grant");

endmodule

bind core_top core_tb_assert i_core_tb_assert (
    .g_clk     (g_clk                   ),
    .rst_n     (rst_n                   ),
    .imem_req  (imem_req                ),
    .imem_gnt  (imem_gnt                ),
    .imem_addr (imem_addr               ),
    .cf_valid  (cf_valid                ),
    .credits   (i_core_fetch.credits    ),
    .occupancy (i_core_instr_queue.count)
);

`default_nettype wire
